//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := job_pe_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "Test FAILED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/job_pe_tb.sv
// testbench for job_pe_top: one table row per job, matcher model with random stalls
// expected sequences follow the lazy selection rules, worked out per row
`default_nettype none
`include "lz_macros.svh"

module job_pe_tb;

  localparam int NROWS = 6;
  localparam int MAX_SEQ = 4;
  localparam int MAX_WIN = 3;
  localparam int CLK_PERIOD = 40;
  localparam int JOB_CYCLES = 120;
  localparam int NUM_BATCHES = `LZ_JOB_LEN / `LZ_ISSUE_WIDTH;

  typedef struct packed {
    logic                          valid;
    logic [`LZ_OFFSET_BITS-1:0]    off;
    logic [`LZ_META_LEN_WIDTH-1:0] meta;
    logic                          ext;
  } pos_t;

  logic clk;
  logic rst_n;
  lz_pkg::hash_batch_t batch;
  logic batch_valid;
  logic batch_ready;
  lz_pkg::match_req_t match_req;
  logic req_valid;
  logic req_ready;
  lz_pkg::match_resp_t match_resp;
  logic resp_valid;
  logic resp_ready;
  lz_pkg::seq_t seq;
  logic seq_valid;
  logic seq_ready;

  // job table: candidates, matcher windows and expected sequences
  pos_t job_pos [NROWS][`LZ_JOB_LEN];
  logic [`LZ_ADDR_WIDTH-1:0] job_base [NROWS];
  logic row_delim [NROWS];
  int n_win [NROWS];
  logic [`LZ_JOB_LEN_LOG2-1:0] win_pos [NROWS][MAX_WIN];
  logic [`LZ_LAZY_LEN-1:0] win_strb [NROWS][MAX_WIN];
  lz_pkg::match_resp_t win_len [NROWS][MAX_WIN];
  int seq_stall [NROWS];
  int n_seq [NROWS];
  lz_pkg::seq_t exp_seq [NROWS][MAX_SEQ];

  int cur_row;
  int win_idx;
  int err_count;
  int check_count;
  logic [7:0] lfsr;

  job_pe_top i_job_pe_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .batch       (batch),
    .batch_valid (batch_valid),
    .batch_ready (batch_ready),
    .match_req   (match_req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .match_resp  (match_resp),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .seq         (seq),
    .seq_valid   (seq_valid),
    .seq_ready   (seq_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic lz_pkg::seq_t mk_seq(input int ll, input int ml, input int off,
                                          input logic eoj, input logic delim);
    lz_pkg::seq_t s;
    s.ll = `LZ_LL_BITS'(ll);
    s.ml = `LZ_ML_BITS'(ml);
    s.offset = `LZ_OFFSET_BITS'(off);
    s.eoj = eoj;
    s.delim = delim;
    return s;
  endfunction

  function automatic lz_pkg::match_resp_t mk_lens(input int a, input int b, input int c);
    lz_pkg::match_resp_t lr;
    lr.match_len[0] = `LZ_MATCH_LEN_WIDTH'(a);
    lr.match_len[1] = `LZ_MATCH_LEN_WIDTH'(b);
    lr.match_len[2] = `LZ_MATCH_LEN_WIDTH'(c);
    return lr;
  endfunction

  function automatic logic [`LZ_ADDR_WIDTH-1:0] hist_of(input int r, input int p);
    return job_base[r] + `LZ_ADDR_WIDTH'(p) - job_pos[r][p].off;
  endfunction

  task automatic set_pos(input int r, input int p, input int off, input int meta,
                         input logic ext);
    job_pos[r][p].valid = 1'b1;
    job_pos[r][p].off = `LZ_OFFSET_BITS'(off);
    job_pos[r][p].meta = `LZ_META_LEN_WIDTH'(meta);
    job_pos[r][p].ext = ext;
  endtask

  task automatic add_win(input int r, input int p, input logic [`LZ_LAZY_LEN-1:0] strb,
                         input lz_pkg::match_resp_t lens);
    win_pos[r][n_win[r]] = `LZ_JOB_LEN_LOG2'(p);
    win_strb[r][n_win[r]] = strb;
    win_len[r][n_win[r]] = lens;
    n_win[r]++;
  endtask

  task automatic add_seq(input int r, input lz_pkg::seq_t s);
    exp_seq[r][n_seq[r]] = s;
    n_seq[r]++;
  endtask

  task automatic build_table();
    for (int r = 0; r < NROWS; r++) begin
      job_base[r] = `LZ_ADDR_WIDTH'(16'h1000 + r * 16'h100);
      row_delim[r] = 1'b0;
      n_win[r] = 0;
      n_seq[r] = 0;
      seq_stall[r] = 0;
      for (int p = 0; p < `LZ_JOB_LEN; p++) begin
        job_pos[r][p] = '0;
      end
    end
    // no candidates at all
    row_delim[0] = 1'b1;
    add_seq(0, mk_seq(16, 0, 0, 1'b1, 1'b1));
    // lone candidate that cannot extend
    row_delim[1] = 1'b1;
    set_pos(1, 5, 100, 5, 1'b0);
    add_seq(1, mk_seq(5, 5, 100, 1'b0, 1'b0));
    add_seq(1, mk_seq(6, 0, 0, 1'b1, 1'b1));
    // position 3 repeats the offset of 2 so only lanes 0 and 2 go out
    set_pos(2, 2, 50, 3, 1'b1);
    set_pos(2, 3, 50, 3, 1'b1);
    set_pos(2, 4, 20, 4, 1'b1);
    add_win(2, 2, 3'b101, mk_lens(2, 9, 6));
    add_seq(2, mk_seq(4, 10, 20, 1'b0, 1'b0));
    add_seq(2, mk_seq(2, 0, 0, 1'b1, 1'b0));
    seq_stall[2] = 1;
    // extended match clipped at the job end
    row_delim[3] = 1'b1;
    set_pos(3, 14, 300, 3, 1'b1);
    add_win(3, 14, 3'b001, mk_lens(7, 0, 0));
    add_seq(3, mk_seq(14, 2, 300, 1'b1, 1'b1));
    // three matches that cover the whole job
    row_delim[4] = 1'b1;
    set_pos(4, 0, 8, 3, 1'b0);
    set_pos(4, 1, 40, 4, 1'b1);
    set_pos(4, 7, 12, 6, 1'b0);
    set_pos(4, 13, 2, 3, 1'b1);
    set_pos(4, 14, 2, 5, 1'b1);
    add_win(4, 0, 3'b010, mk_lens(5, 1, 7));
    add_win(4, 13, 3'b001, mk_lens(0, 4, 0));
    add_seq(4, mk_seq(1, 5, 40, 1'b0, 1'b0));
    add_seq(4, mk_seq(1, 6, 12, 1'b0, 1'b0));
    add_seq(4, mk_seq(1, 2, 2, 1'b1, 1'b1));
    // tie between entries 0 and 1, long output stalls
    set_pos(5, 3, 7, 4, 1'b1);
    set_pos(5, 4, 9, 5, 1'b1);
    set_pos(5, 5, 11, 3, 1'b0);
    add_win(5, 3, 3'b011, mk_lens(2, 2, 5));
    add_seq(5, mk_seq(3, 6, 7, 1'b0, 1'b0));
    add_seq(5, mk_seq(7, 0, 0, 1'b1, 1'b0));
    seq_stall[5] = 3;
  endtask

  function automatic lz_pkg::hash_batch_t build_batch(input int r, input int b);
    lz_pkg::hash_batch_t hb;
    int p;
    hb = '0;
    hb.head_addr = job_base[r] + `LZ_ADDR_WIDTH'(b * `LZ_ISSUE_WIDTH);
    for (int l = 0; l < `LZ_ISSUE_WIDTH; l++) begin
      p = b * `LZ_ISSUE_WIDTH + l;
      hb.hist_valid[l] = job_pos[r][p].valid;
      hb.meta_len[l] = job_pos[r][p].meta;
      hb.can_ext[l] = job_pos[r][p].ext;
      if (job_pos[r][p].valid) begin
        hb.hist_addr[l] = hist_of(r, p);
      end
    end
    // earlier batches carry the opposite delim
    hb.delim = (b == NUM_BATCHES - 1) ? row_delim[r] : !row_delim[r];
    return hb;
  endfunction

  task automatic send_job(input int r);
    for (int b = 0; b < NUM_BATCHES; b++) begin
      @(negedge clk);
      batch = build_batch(r, b);
      batch_valid = 1'b1;
      while (!batch_ready) @(negedge clk);
    end
    @(negedge clk);
    batch_valid = 1'b0;
    batch = '0;
  endtask

  task automatic check_request(input int r, input int w, input lz_pkg::match_req_t req);
    int p;
    check_count++;
    assert (w < n_win[r]) else begin
      err_count++;
      $display("Error at %0t: job %0d sent more match requests than expected", $time, r);
    end
    if (w < n_win[r]) begin
      check_count++;
      assert (req.strb == win_strb[r][w]) else begin
        err_count++;
        $display("Mismatch at %0t: job %0d window %0d strobe %b, expected %b",
                 $time, r, w, req.strb, win_strb[r][w]);
      end
      for (int i = 0; i < `LZ_LAZY_LEN; i++) begin
        p = int'(win_pos[r][w]) + i;
        if (win_strb[r][w][i]) begin
          check_count++;
          assert (req.head_addr[i] == job_base[r] + `LZ_ADDR_WIDTH'(p + `LZ_META_HISTORY_LEN)
                  && req.history_addr[i] ==
                     hist_of(r, p) + `LZ_ADDR_WIDTH'(`LZ_META_HISTORY_LEN)) else begin
            err_count++;
            $display("Mismatch at %0t: job %0d window %0d lane %0d addresses %h/%h",
                     $time, r, w, i, req.head_addr[i], req.history_addr[i]);
          end
        end
      end
    end
  endtask

  task automatic collect_seqs(input int r);
    lz_pkg::seq_t got;
    int total;
    total = 0;
    for (int k = 0; k < n_seq[r]; k++) begin
      do @(negedge clk); while (!seq_valid);
      got = seq;
      for (int s = 0; s < seq_stall[r]; s++) begin
        @(negedge clk);
        check_count++;
        assert (seq_valid && seq == got) else begin
          err_count++;
          $display("Error at %0t: sequence output changed while seq_ready was low", $time);
        end
      end
      check_count++;
      assert (got == exp_seq[r][k]) else begin
        err_count++;
        $display("Mismatch at %0t: job %0d seq %0d got ll=%0d ml=%0d off=%0d eoj=%b delim=%b",
                 $time, r, k, got.ll, got.ml, got.offset, got.eoj, got.delim);
        $display("  expected ll=%0d ml=%0d off=%0d eoj=%b delim=%b", exp_seq[r][k].ll,
                 exp_seq[r][k].ml, exp_seq[r][k].offset, exp_seq[r][k].eoj,
                 exp_seq[r][k].delim);
      end
      total += int'(got.ll) + int'(got.ml);
      seq_ready = 1'b1;
      @(negedge clk);
      seq_ready = 1'b0;
    end
    check_count++;
    assert (total == `LZ_JOB_LEN) else begin
      err_count++;
      $display("Mismatch at %0t: job %0d sequences cover %0d positions", $time, r, total);
    end
    check_count++;
    assert (batch_ready && !seq_valid) else begin
      err_count++;
      $display("Error at %0t: job %0d did not return to loading after its last sequence",
               $time, r);
    end
  endtask

  // answers each request after a random stall
  initial begin : matcher_model
    lz_pkg::match_req_t held;
    int stall;
    int w;
    req_ready = 1'b0;
    resp_valid = 1'b0;
    match_resp = '0;
    wait (rst_n == 1'b1);
    forever begin
      do @(negedge clk); while (!req_valid);
      held = match_req;
      draw_bits(2, stall);
      repeat (stall) begin
        @(negedge clk);
        check_count++;
        assert (req_valid && match_req == held) else begin
          err_count++;
          $display("Error at %0t: match request changed while req_ready was low", $time);
        end
      end
      w = win_idx;
      check_request(cur_row, w, held);
      req_ready = 1'b1;
      @(negedge clk);
      req_ready = 1'b0;
      draw_bits(2, stall);
      repeat (stall) @(negedge clk);
      if (w < MAX_WIN) begin
        match_resp = win_len[cur_row][w];
      end
      resp_valid = 1'b1;
      while (!resp_ready) @(negedge clk);
      @(negedge clk);
      resp_valid = 1'b0;
      match_resp = '0;
      win_idx++;
    end
  end

  initial begin : watchdog
    #(NROWS * JOB_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", NROWS * JOB_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main_flow
    rst_n = 1'b0;
    batch = '0;
    batch_valid = 1'b0;
    seq_ready = 1'b0;
    err_count = 0;
    check_count = 0;
    lfsr = 8'd61;
    win_idx = 0;
    cur_row = 0;
    build_table();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_count++;
    assert (batch_ready && !req_valid && !resp_ready && !seq_valid) else begin
      err_count++;
      $display("Error at %0t: handshake outputs not in their reset state", $time);
    end
    for (int r = 0; r < NROWS; r++) begin
      cur_row = r;
      win_idx = 0;
      fork
        send_job(r);
        collect_seqs(r);
      join
      check_count++;
      assert (win_idx == n_win[r]) else begin
        err_count++;
        $display("Error at %0t: job %0d made %0d match requests instead of %0d",
                 $time, r, win_idx, n_win[r]);
      end
    end
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/lz_pkg.sv
source/job_table.sv
source/job_control.sv
source/lazy_window.sv
source/seq_summary.sv
source/job_pe_top.sv
bench/job_pe_tb.sv

//--- source/job_control.sv
// job FSM with one lazy window in flight at a time
// seek skips 8, 4 or 1 invalid positions per cycle
`default_nettype none
`include "lz_macros.svh"

module job_control (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load_done,
  input  logic [`LZ_JOB_LEN-1:0]        tbl_valid,
  input  logic                          pending_any,
  input  logic                          req_ready,
  input  logic                          resp_valid,
  input  logic                          seq_valid,
  input  logic                          seq_ready,
  input  logic [`LZ_JOB_LEN_LOG2:0]     move_forward,
  input  logic                          end_of_job,
  output lz_pkg::job_state_e            state,
  output logic [`LZ_JOB_LEN_LOG2-1:0]   seq_head_ptr,
  output logic [`LZ_JOB_LEN_LOG2-1:0]   match_head_ptr
);

  localparam int PW = `LZ_JOB_LEN_LOG2;

  logic [`LZ_JOB_LEN-1:0] ahead;
  logic seq_fire;
  logic [PW-1:0] next_head;

  // valid bits from the match head onward
  assign ahead = tbl_valid >> match_head_ptr;
  assign seq_fire = seq_valid && seq_ready;
  assign next_head = seq_head_ptr + move_forward[PW-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= lz_pkg::s_load;
      seq_head_ptr <= '0;
      match_head_ptr <= '0;
    end else begin
      case (state)
        lz_pkg::s_load: begin
          seq_head_ptr <= '0;
          match_head_ptr <= '0;
          if (load_done) begin
            state <= lz_pkg::s_seek;
          end
        end
        lz_pkg::s_seek: begin
          if (ahead[0]) begin
            state <= lz_pkg::s_match_req;
          end else if (match_head_ptr == PW'(`LZ_JOB_LEN - 1)) begin
            state <= lz_pkg::s_lit_tail;
          end else if (match_head_ptr < PW'(`LZ_JOB_LEN - 8) && ahead[7:0] == '0) begin
            match_head_ptr <= match_head_ptr + PW'(8);
          end else if (match_head_ptr < PW'(`LZ_JOB_LEN - 4) && ahead[3:0] == '0) begin
            match_head_ptr <= match_head_ptr + PW'(4);
          end else begin
            match_head_ptr <= match_head_ptr + 1'b1;
          end
        end
        lz_pkg::s_match_req: begin
          // nothing to extend, go straight to selection
          if (!pending_any) begin
            state <= lz_pkg::s_summary;
          end else if (req_ready) begin
            state <= lz_pkg::s_match_resp;
          end
        end
        lz_pkg::s_match_resp: begin
          if (resp_valid) begin
            state <= lz_pkg::s_summary;
          end
        end
        lz_pkg::s_summary: begin
          if (seq_fire) begin
            seq_head_ptr <= next_head;
            match_head_ptr <= next_head;
            state <= end_of_job ? lz_pkg::s_load : lz_pkg::s_seek;
          end
        end
        lz_pkg::s_lit_tail: begin
          if (seq_fire) begin
            state <= lz_pkg::s_load;
          end
        end
        default: begin
          state <= lz_pkg::s_load;
        end
      endcase
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {lz_pkg::s_load, lz_pkg::s_seek, lz_pkg::s_match_req,
                  lz_pkg::s_match_resp, lz_pkg::s_summary, lz_pkg::s_lit_tail});

endmodule

`default_nettype wire

//--- source/job_pe_top.sv
// one job PE: table, FSM, lazy window and summary
// a single window is outstanding at the external matcher
`default_nettype none
`include "lz_macros.svh"

module job_pe_top (
  input  logic                clk,
  input  logic                rst_n,
  input  lz_pkg::hash_batch_t batch,
  input  logic                batch_valid,
  output logic                batch_ready,
  output lz_pkg::match_req_t  match_req,
  output logic                req_valid,
  input  logic                req_ready,
  input  lz_pkg::match_resp_t match_resp,
  input  logic                resp_valid,
  output logic                resp_ready,
  output lz_pkg::seq_t        seq,
  output logic                seq_valid,
  input  logic                seq_ready
);

  lz_pkg::job_state_e state;
  logic [`LZ_JOB_LEN_LOG2-1:0] seq_head_ptr;
  logic [`LZ_JOB_LEN_LOG2-1:0] match_head_ptr;
  lz_pkg::job_entry_t [`LZ_JOB_LEN-1:0] job_tbl;
  logic [`LZ_JOB_LEN-1:0] tbl_valid;
  logic [`LZ_ADDR_WIDTH-1:0] job_head_addr;
  logic job_delim;
  logic load_done;
  lz_pkg::lazy_entry_t [`LZ_LAZY_LEN-1:0] window;
  logic pending_any;
  logic [`LZ_JOB_LEN_LOG2:0] move_forward;
  logic end_of_job;

  for (genvar p = 0; p < `LZ_JOB_LEN; p++) begin : g_tbl_valid
    assign tbl_valid[p] = job_tbl[p].valid;
  end

  job_table i_job_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .state         (state),
    .batch         (batch),
    .batch_valid   (batch_valid),
    .batch_ready   (batch_ready),
    .job_tbl       (job_tbl),
    .job_head_addr (job_head_addr),
    .job_delim     (job_delim),
    .load_done     (load_done)
  );

  job_control i_job_control (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_done      (load_done),
    .tbl_valid      (tbl_valid),
    .pending_any    (pending_any),
    .req_ready      (req_ready),
    .resp_valid     (resp_valid),
    .seq_valid      (seq_valid),
    .seq_ready      (seq_ready),
    .move_forward   (move_forward),
    .end_of_job     (end_of_job),
    .state          (state),
    .seq_head_ptr   (seq_head_ptr),
    .match_head_ptr (match_head_ptr)
  );

  lazy_window i_lazy_window (
    .clk            (clk),
    .state          (state),
    .match_head_ptr (match_head_ptr),
    .job_tbl        (job_tbl),
    .job_head_addr  (job_head_addr),
    .match_resp     (match_resp),
    .resp_valid     (resp_valid),
    .window         (window),
    .pending_any    (pending_any),
    .match_req      (match_req),
    .req_valid      (req_valid),
    .resp_ready     (resp_ready)
  );

  seq_summary i_seq_summary (
    .clk            (clk),
    .state          (state),
    .window         (window),
    .seq_head_ptr   (seq_head_ptr),
    .match_head_ptr (match_head_ptr),
    .job_delim      (job_delim),
    .seq            (seq),
    .seq_valid      (seq_valid),
    .move_forward   (move_forward),
    .end_of_job     (end_of_job)
  );

endmodule

`default_nettype wire

//--- source/job_table.sv
// loads one job as JOB_LEN / ISSUE_WIDTH back-to-back batches in s_load
// offsets use the raw history address, the stored address carries the bias
`default_nettype none
`include "lz_macros.svh"

module job_table (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  lz_pkg::job_state_e                   state,
  input  lz_pkg::hash_batch_t                  batch,
  input  logic                                 batch_valid,
  output logic                                 batch_ready,
  output lz_pkg::job_entry_t [`LZ_JOB_LEN-1:0] job_tbl,
  output logic [`LZ_ADDR_WIDTH-1:0]            job_head_addr,
  output logic                                 job_delim,
  output logic                                 load_done
);

  localparam int NUM_BATCHES = `LZ_JOB_LEN / `LZ_ISSUE_WIDTH;
  localparam int CNT_W = $clog2(NUM_BATCHES);

  logic [CNT_W-1:0] batch_cnt;
  logic batch_fire;
  lz_pkg::job_entry_t [`LZ_ISSUE_WIDTH-1:0] lane_entry;

  assign batch_ready = (state == lz_pkg::s_load);
  assign batch_fire = batch_valid && batch_ready;
  assign load_done = batch_fire && (batch_cnt == CNT_W'(NUM_BATCHES - 1));

  always_comb begin
    for (int l = 0; l < `LZ_ISSUE_WIDTH; l++) begin
      lane_entry[l].valid = batch.hist_valid[l];
      lane_entry[l].hist_addr = batch.hist_addr[l] +
                                `LZ_ADDR_WIDTH'(`LZ_META_HISTORY_LEN);
      lane_entry[l].meta_len = batch.meta_len[l];
      lane_entry[l].can_ext = batch.can_ext[l];
      // distance back from this lane's byte, zero when no candidate
      lane_entry[l].offset = batch.hist_valid[l] ?
          `LZ_OFFSET_BITS'(batch.head_addr + `LZ_ADDR_WIDTH'(l) - batch.hist_addr[l]) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      batch_cnt <= '0;
    end else if (batch_fire) begin
      batch_cnt <= load_done ? '0 : batch_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (batch_fire) begin
      for (int l = 0; l < `LZ_ISSUE_WIDTH; l++) begin
        job_tbl[int'(batch_cnt) * `LZ_ISSUE_WIDTH + l] <= lane_entry[l];
      end
      if (batch_cnt == '0) begin
        job_head_addr <= batch.head_addr;
      end
      // delim belongs to the job, only the last batch has it
      if (load_done) begin
        job_delim <= batch.delim;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/lazy_window.sv
// lazy window of LAZY_LEN positions from the match head
// only pending entries are sent to the matcher and take its lengths
`default_nettype none
`include "lz_macros.svh"

module lazy_window (
  input  logic                                   clk,
  input  lz_pkg::job_state_e                     state,
  input  logic [`LZ_JOB_LEN_LOG2-1:0]            match_head_ptr,
  input  lz_pkg::job_entry_t [`LZ_JOB_LEN-1:0]   job_tbl,
  input  logic [`LZ_ADDR_WIDTH-1:0]              job_head_addr,
  input  lz_pkg::match_resp_t                    match_resp,
  input  logic                                   resp_valid,
  output lz_pkg::lazy_entry_t [`LZ_LAZY_LEN-1:0] window,
  output logic                                   pending_any,
  output lz_pkg::match_req_t                     match_req,
  output logic                                   req_valid,
  output logic                                   resp_ready
);

  localparam int PW = `LZ_JOB_LEN_LOG2;

  logic load_en;
  logic resp_fire;
  logic [PW:0] pos [`LZ_LAZY_LEN];
  logic [PW-1:0] idx [`LZ_LAZY_LEN];
  lz_pkg::lazy_entry_t [`LZ_LAZY_LEN-1:0] fill;
  logic [`LZ_LAZY_LEN-1:0] pending_vec;

  assign load_en = (state == lz_pkg::s_seek) && job_tbl[match_head_ptr].valid;
  assign resp_ready = (state == lz_pkg::s_match_resp);
  assign resp_fire = resp_ready && resp_valid;

  always_comb begin
    for (int i = 0; i < `LZ_LAZY_LEN; i++) begin
      pos[i] = {1'b0, match_head_ptr} + (PW+1)'(i);
      idx[i] = pos[i][PW-1:0];
      fill[i] = '0;
      // entries past the job end stay invalid
      if (pos[i] < (PW+1)'(`LZ_JOB_LEN)) begin
        fill[i].valid = job_tbl[idx[i]].valid;
        fill[i].pending = job_tbl[idx[i]].valid && job_tbl[idx[i]].can_ext;
        // same offset as the position before repeats its match
        if (i > 0 && job_tbl[idx[i]].offset == job_tbl[idx[i] - 1'b1].offset) begin
          fill[i].pending = 1'b0;
        end
        fill[i].head_addr = job_head_addr + `LZ_ADDR_WIDTH'(idx[i]) +
                            `LZ_ADDR_WIDTH'(`LZ_META_HISTORY_LEN);
        fill[i].history_addr = job_tbl[idx[i]].hist_addr;
        fill[i].match_len = `LZ_MATCH_LEN_WIDTH'(job_tbl[idx[i]].meta_len);
        fill[i].offset = job_tbl[idx[i]].offset;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      window <= fill;
    end else if (resp_fire) begin
      for (int i = 0; i < `LZ_LAZY_LEN; i++) begin
        if (window[i].pending) begin
          window[i].match_len <= window[i].match_len + match_resp.match_len[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `LZ_LAZY_LEN; i++) begin
      pending_vec[i] = window[i].pending;
      match_req.head_addr[i] = window[i].head_addr;
      match_req.history_addr[i] = window[i].history_addr;
    end
    match_req.strb = pending_vec;
  end

  assign pending_any = |pending_vec;
  assign req_valid = (state == lz_pkg::s_match_req) && pending_any;

  // the window must not lose its pending entries while a request is open
  a_req_pending: assert property (@(posedge clk)
    req_valid |=> pending_any &&
                  (state inside {lz_pkg::s_match_req, lz_pkg::s_match_resp}));

endmodule

`default_nettype wire

//--- source/lz_macros.svh
// job geometry and field widths for the job PE
// JOB_LEN must be a multiple of ISSUE_WIDTH, and JOB_LEN_LOG2 must match JOB_LEN
`ifndef LZ_MACROS_SVH
`define LZ_MACROS_SVH

// job geometry
`define LZ_JOB_LEN          16
`define LZ_JOB_LEN_LOG2     4
`define LZ_ISSUE_WIDTH      4
`define LZ_LAZY_LEN         3

// addresses and lengths
`define LZ_ADDR_WIDTH       16
`define LZ_META_LEN_WIDTH   3
`define LZ_MATCH_LEN_WIDTH  8

// sequence fields
`define LZ_OFFSET_BITS      16
`define LZ_LL_BITS          8
`define LZ_ML_BITS          8

// both request addresses skip the bytes the hash engine already matched
`define LZ_META_HISTORY_LEN 4

`endif

//--- source/lz_pkg.sv
// shared types for the job PE; all widths come from lz_macros.svh
`default_nettype none
`include "lz_macros.svh"

package lz_pkg;

  typedef enum logic [2:0] {
    s_load,
    s_seek,
    s_match_req,
    s_match_resp,
    s_summary,
    s_lit_tail
  } job_state_e;

  typedef struct packed {
    logic [`LZ_ADDR_WIDTH-1:0]                          head_addr;
    logic [`LZ_ISSUE_WIDTH-1:0]                         hist_valid;
    logic [`LZ_ISSUE_WIDTH-1:0][`LZ_ADDR_WIDTH-1:0]     hist_addr;
    logic [`LZ_ISSUE_WIDTH-1:0][`LZ_META_LEN_WIDTH-1:0] meta_len;
    logic [`LZ_ISSUE_WIDTH-1:0]                         can_ext;
    logic                                               delim;
  } hash_batch_t;

  // hist_addr here is already biased
  typedef struct packed {
    logic                          valid;
    logic [`LZ_ADDR_WIDTH-1:0]     hist_addr;
    logic [`LZ_META_LEN_WIDTH-1:0] meta_len;
    logic                          can_ext;
    logic [`LZ_OFFSET_BITS-1:0]    offset;
  } job_entry_t;

  typedef struct packed {
    logic                           valid;
    logic                           pending;
    logic [`LZ_ADDR_WIDTH-1:0]      head_addr;
    logic [`LZ_ADDR_WIDTH-1:0]      history_addr;
    logic [`LZ_MATCH_LEN_WIDTH-1:0] match_len;
    logic [`LZ_OFFSET_BITS-1:0]     offset;
  } lazy_entry_t;

  typedef struct packed {
    logic [`LZ_LAZY_LEN-1:0][`LZ_ADDR_WIDTH-1:0] head_addr;
    logic [`LZ_LAZY_LEN-1:0][`LZ_ADDR_WIDTH-1:0] history_addr;
    logic [`LZ_LAZY_LEN-1:0]                     strb;
  } match_req_t;

  typedef struct packed {
    logic [`LZ_LAZY_LEN-1:0][`LZ_MATCH_LEN_WIDTH-1:0] match_len;
  } match_resp_t;

  typedef struct packed {
    logic [`LZ_LL_BITS-1:0]     ll;
    logic [`LZ_ML_BITS-1:0]     ml;
    logic [`LZ_OFFSET_BITS-1:0] offset;
    logic                       eoj;
    logic                       delim;
  } seq_t;

endpackage

`default_nettype wire

//--- source/seq_summary.sv
// picks the best window entry through one register stage
// seq_valid comes up on the second summary cycle; the literal tail is immediate
`default_nettype none
`include "lz_macros.svh"

module seq_summary (
  input  logic                                   clk,
  input  lz_pkg::job_state_e                     state,
  input  lz_pkg::lazy_entry_t [`LZ_LAZY_LEN-1:0] window,
  input  logic [`LZ_JOB_LEN_LOG2-1:0]            seq_head_ptr,
  input  logic [`LZ_JOB_LEN_LOG2-1:0]            match_head_ptr,
  input  logic                                   job_delim,
  output lz_pkg::seq_t                           seq,
  output logic                                   seq_valid,
  output logic [`LZ_JOB_LEN_LOG2:0]              move_forward,
  output logic                                   end_of_job
);

  localparam int PW = `LZ_JOB_LEN_LOG2;
  localparam int SW = `LZ_MATCH_LEN_WIDTH + 2;
  localparam int IW = $clog2(`LZ_LAZY_LEN);

  logic signed [SW-1:0] score;
  logic signed [SW-1:0] best_score;
  logic [IW-1:0] best_idx;
  lz_pkg::lazy_entry_t best;
  logic [PW:0] match_pos;
  logic [PW:0] room;
  logic [`LZ_ML_BITS-1:0] ml_clip;
  logic [PW:0] pick_forward;
  lz_pkg::seq_t pick;
  lz_pkg::seq_t pick_q;
  logic [PW:0] forward_q;
  logic sel_q;
  logic [PW:0] tail_ll;
  lz_pkg::seq_t tail;

  // gain of entry i is match_len - i, ties keep the earlier entry
  always_comb begin
    best_idx = '0;
    best_score = $signed({2'b00, window[0].match_len});
    for (int i = 1; i < `LZ_LAZY_LEN; i++) begin
      score = $signed({2'b00, window[i].match_len}) - SW'(i);
      if (window[i].valid && score > best_score) begin
        best_idx = IW'(i);
        best_score = score;
      end
    end
  end

  assign best = window[best_idx];
  assign match_pos = {1'b0, match_head_ptr} + (PW+1)'(best_idx);
  // clip so the match stops at the job end
  assign room = (PW+1)'(`LZ_JOB_LEN) - match_pos;
  assign ml_clip = (best.match_len > `LZ_MATCH_LEN_WIDTH'(room)) ?
                   `LZ_ML_BITS'(room) : `LZ_ML_BITS'(best.match_len);
  assign pick_forward = match_pos - {1'b0, seq_head_ptr} + (PW+1)'(ml_clip);

  always_comb begin
    pick.ll = `LZ_LL_BITS'(match_pos - {1'b0, seq_head_ptr});
    pick.ml = ml_clip;
    pick.offset = best.offset;
    pick.eoj = ({1'b0, seq_head_ptr} + pick_forward) >= (PW+1)'(`LZ_JOB_LEN);
    pick.delim = pick.eoj && job_delim;
  end

  always_ff @(posedge clk) begin
    sel_q <= (state == lz_pkg::s_summary);
    pick_q <= pick;
    forward_q <= pick_forward;
  end

  // rest of the job as literals
  assign tail_ll = (PW+1)'(`LZ_JOB_LEN) - {1'b0, seq_head_ptr};

  always_comb begin
    tail.ll = `LZ_LL_BITS'(tail_ll);
    tail.ml = '0;
    tail.offset = '0;
    tail.eoj = 1'b1;
    tail.delim = job_delim;
  end

  assign seq_valid = ((state == lz_pkg::s_summary) && sel_q) ||
                     (state == lz_pkg::s_lit_tail);
  assign seq = (state == lz_pkg::s_lit_tail) ? tail : pick_q;
  assign move_forward = (state == lz_pkg::s_lit_tail) ? tail_ll : forward_q;
  assign end_of_job = seq.eoj;

  // no sequence reaches past the job end
  a_ml_bound: assert property (@(posedge clk)
    seq_valid |-> seq.ml <= `LZ_ML_BITS'(`LZ_JOB_LEN) &&
                  ({1'b0, seq_head_ptr} + move_forward) <= (PW+1)'(`LZ_JOB_LEN));

endmodule

`default_nettype wire
